// ==== flist.f ====
logic/axi_lite_pkg.sv
logic/dma_regs_pkg.sv
logic/axi_write_channel.sv
logic/dma_reg_slice.sv
logic/axi_read_channel.sv
logic/dma_regs_top.sv
tests/dma_regs_checker.sv
tests/tb_dma_regs.sv

// ==== run.sh ====
#!/bin/sh
# Build the DMA register block testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dma_regs \
  -f flist.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Let every assertion failure be counted instead of stopping at the first
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tests/tb_dma_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Drives random AXI4-Lite traffic into the DMA register block
// Runs with the bound checker and reads its failure count at the end
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dma_regs;

  import axi_lite_pkg::*;
  import dma_regs_pkg::*;

  // Cycles allowed for any single wait
  localparam int WAIT_LIMIT = 20;

  logic                  S_AXI_ACLK;
  logic                  S_AXI_ARESETN;
  logic [AXI_ADDR_W-1:0] s_axi_awaddr;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  logic [AXI_DATA_W-1:0] s_axi_wdata;
  logic [AXI_STRB_W-1:0] s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  logic [1:0]            s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  logic [AXI_ADDR_W-1:0] s_axi_araddr;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  logic [AXI_DATA_W-1:0] s_axi_rdata;
  logic [1:0]            s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;
  reg_word_t             cmd;
  reg_word_t             num_pkts;

  logic [31:0] lcg_state;
  int          timeouts;
  // Write response or read data still waiting for the master
  logic        b_pending;
  logic        r_pending;

  dma_regs_top dut (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .cmd           (cmd),
    .num_pkts      (num_pkts)
  );

  // 20 ns clock
  always #10 S_AXI_ACLK = ~S_AXI_ACLK;

  // Advance the LCG and return the new state
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Bus transactions
  ////////////////////////////////////////////////////////////////////////

  // One bready handshake on the pending write response
  task automatic take_write_resp();
    int waited;
    s_axi_bready = 1'b1;
    waited = 0;
    while (!s_axi_bvalid && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      timeouts++;
      $display("No write response came back for the last write");
    end
    next_cycle();
    s_axi_bready = 1'b0;
    b_pending    = 1'b0;
  endtask

  // One rready handshake on the pending read data
  task automatic take_read_data();
    int waited;
    s_axi_rready = 1'b1;
    waited = 0;
    while (!s_axi_rvalid && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      timeouts++;
      $display("No read data came back for the last read");
    end
    next_cycle();
    s_axi_rready = 1'b0;
    r_pending    = 1'b0;
  endtask

  task automatic write_reg(input int slot, input logic [31:0] data, input logic [3:0] strb);
    int          waited;
    logic [31:0] r;
    s_axi_awaddr  = AXI_ADDR_W'(slot << ADDR_LSB);
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    // New write sits on the bus while the last response is held back
    if (b_pending)
    begin
      r = next_rand();
      repeat (1 + int'(r[29:28])) next_cycle();
      take_write_resp();
    end
    waited = 0;
    while (!(s_axi_awready && s_axi_wready) && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    // Handshake happens at the next edge
    next_cycle();
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    if (waited >= WAIT_LIMIT)
    begin
      timeouts++;
      $display("Write to slot %0d was never accepted by awready and wready", slot);
      return;
    end
    // Response is claimed by the next write
    b_pending = 1'b1;
  endtask

  task automatic read_reg(input int slot);
    int          waited;
    logic [31:0] r;
    s_axi_araddr  = AXI_ADDR_W'(slot << ADDR_LSB);
    s_axi_arvalid = 1'b1;
    // New address sits on the bus while the last read data is held back
    if (r_pending)
    begin
      r = next_rand();
      repeat (1 + int'(r[29:28])) next_cycle();
      take_read_data();
    end
    waited = 0;
    while (!s_axi_arready && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    next_cycle();
    s_axi_arvalid = 1'b0;
    if (waited >= WAIT_LIMIT)
    begin
      timeouts++;
      $display("Read of slot %0d was never accepted by arready", slot);
      return;
    end
    // Read data is claimed by the next read
    r_pending = 1'b1;
  endtask

  task automatic apply_reset();
    S_AXI_ARESETN = 1'b0;
    repeat (3) next_cycle();
    S_AXI_ARESETN = 1'b1;
    // Reset drops whatever was still pending
    b_pending = 1'b0;
    r_pending = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    S_AXI_ACLK    = 1'b0;
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    lcg_state     = 32'hb56d;
    timeouts      = 0;
    b_pending     = 1'b0;
    r_pending     = 1'b0;

    // Reset held for 3 cycles and released 1 ns after the edge
    repeat (3) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;

    // Full words into all eight slots and read them back
    for (int a = 0; a < 8; a++)
    begin
      write_reg(a, 32'h0101_0101 * (a + 1) ^ 32'hc3a5_0000, 4'hf);
    end
    for (int a = 0; a < 8; a++)
    begin
      read_reg(a);
    end

    // Partial strobes over the earlier words
    for (int a = 0; a < 8; a++)
    begin
      write_reg(a, next_rand(), 4'b0101);
      write_reg(a, next_rand(), 4'b1000);
      read_reg(a);
    end

    // Mixed random traffic
    for (int n = 0; n < 300; n++)
    begin
      r = next_rand();
      if (r[31])
      begin
        write_reg(int'(r[30:28]), next_rand(), r[27:24]);
      end
      else
      begin
        read_reg(int'(r[30:28]));
      end
    end

    // Reset with loaded registers and read every slot back as zero
    apply_reset();
    for (int a = 0; a < 8; a++)
    begin
      read_reg(a);
    end
    if (r_pending)
    begin
      take_read_data();
    end
    repeat (5) next_cycle();

    $display("Run complete: %0d assertion failures, %0d timeouts",
             dut.u_checker.fail_count, timeouts);
    if (dut.u_checker.fail_count == 0 && timeouts == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tests/dma_regs_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Bound assertions for the DMA register block, with a shadow register file
// rebuilt from the AXI4-Lite handshakes seen on the top level ports
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_regs_checker (
  input logic                                S_AXI_ACLK,
  input logic                                S_AXI_ARESETN,
  input logic [axi_lite_pkg::AXI_ADDR_W-1:0] s_axi_awaddr,
  input logic                                s_axi_awvalid,
  input logic                                s_axi_awready,
  input logic [axi_lite_pkg::AXI_DATA_W-1:0] s_axi_wdata,
  input logic [axi_lite_pkg::AXI_STRB_W-1:0] s_axi_wstrb,
  input logic                                s_axi_wvalid,
  input logic                                s_axi_wready,
  input logic [1:0]                          s_axi_bresp,
  input logic                                s_axi_bvalid,
  input logic                                s_axi_bready,
  input logic [axi_lite_pkg::AXI_ADDR_W-1:0] s_axi_araddr,
  input logic                                s_axi_arvalid,
  input logic                                s_axi_arready,
  input logic [axi_lite_pkg::AXI_DATA_W-1:0] s_axi_rdata,
  input logic [1:0]                          s_axi_rresp,
  input logic                                s_axi_rvalid,
  input logic                                s_axi_rready,
  input dma_regs_pkg::reg_word_t             cmd,
  input dma_regs_pkg::reg_word_t             num_pkts
);

  import axi_lite_pkg::*;
  import dma_regs_pkg::*;

  // Per-assertion failure counts, one writer each
  int c_reset = 0;
  int c_rdata = 0;
  int c_outs  = 0;
  int c_bhold = 0;
  int c_rhold = 0;
  int c_okay  = 0;
  int c_one   = 0;
  // Total, read by the testbench at the end of the run
  int fail_count;

  // Eight slots, slot 7 is never written and stays zero
  reg_word_t            shadow [1 << REG_IDX_W];
  reg_word_t            exp_rdata;
  logic [REG_IDX_W-1:0] aw_idx;
  logic [REG_IDX_W-1:0] ar_idx;
  logic                 wr_hs;

  assign fail_count = c_reset + c_rdata + c_outs + c_bhold + c_rhold + c_okay + c_one;
  assign aw_idx = s_axi_awaddr[AXI_ADDR_W-1:ADDR_LSB];
  assign ar_idx = s_axi_araddr[AXI_ADDR_W-1:ADDR_LSB];
  assign wr_hs  = s_axi_awvalid && s_axi_awready && s_axi_wvalid && s_axi_wready;

  ////////////////////////////////////////////////////////////////////////
  // Shadow model
  ////////////////////////////////////////////////////////////////////////

  // Strobed lanes of each accepted write land in the shadow word
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < (1 << REG_IDX_W); i++)
      begin
        shadow[i] <= '0;
      end
    end
    else if (wr_hs && (int'(aw_idx) < NUM_REGS))
    begin
      for (int b = 0; b < AXI_STRB_W; b++)
      begin
        if (s_axi_wstrb[b])
        begin
          shadow[aw_idx][b*8 +: 8] <= s_axi_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Expected read word, taken as the read address is accepted
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (s_axi_arvalid && s_axi_arready)
    begin
      exp_rdata <= shadow[ar_idx];
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////

  // Idle outputs and cleared words one edge after reset is seen
  a_reset_idle: assert property (@(posedge S_AXI_ACLK)
    !S_AXI_ARESETN |=> !s_axi_awready && !s_axi_wready && !s_axi_bvalid
                       && !s_axi_arready && !s_axi_rvalid && cmd == '0 && num_pkts == '0)
    else
    begin
      c_reset++;
      $error("Outputs not idle or registers not cleared after reset");
    end

  // Read data matches the merged history of writes to that slot
  a_rdata: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid |-> s_axi_rdata == exp_rdata)
    else
    begin
      c_rdata++;
      $error("ERROR t=%0t s_axi_rdata=%h expected %h", $time,
             $sampled(s_axi_rdata), $sampled(exp_rdata));
    end

  // Engine outputs follow the shadow words
  a_outputs: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    cmd == shadow[REG_CMD] && num_pkts == shadow[REG_NUM_PKTS])
    else
    begin
      c_outs++;
      $error("ERROR t=%0t cmd=%h expected %h num_pkts=%h expected %h", $time,
             $sampled(cmd), $sampled(shadow[REG_CMD]),
             $sampled(num_pkts), $sampled(shadow[REG_NUM_PKTS]));
    end

  // A pending write response holds until bready
  a_b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
    else
    begin
      c_bhold++;
      $error("Write response dropped or changed before bready");
    end

  // Pending read data holds until rready
  a_r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=>
      s_axi_rvalid && $stable(s_axi_rdata) && $stable(s_axi_rresp))
    else
    begin
      c_rhold++;
      $error("Read data dropped or changed before rready");
    end

  a_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (!s_axi_bvalid || s_axi_bresp == RESP_OKAY) && (!s_axi_rvalid || s_axi_rresp == RESP_OKAY))
    else
    begin
      c_okay++;
      $error("ERROR t=%0t response bresp=%h rresp=%h expected %h", $time,
             $sampled(s_axi_bresp), $sampled(s_axi_rresp), RESP_OKAY);
    end

  // One outstanding transfer per direction
  a_one_out: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !(s_axi_bvalid && (s_axi_awready || s_axi_wready)) && !(s_axi_rvalid && s_axi_arready))
    else
    begin
      c_one++;
      $error("Address ready pulsed while a response was still pending");
    end

endmodule

bind dma_regs_top dma_regs_checker u_checker (
  .S_AXI_ACLK    (S_AXI_ACLK),
  .S_AXI_ARESETN (S_AXI_ARESETN),
  .s_axi_awaddr  (s_axi_awaddr),
  .s_axi_awvalid (s_axi_awvalid),
  .s_axi_awready (s_axi_awready),
  .s_axi_wdata   (s_axi_wdata),
  .s_axi_wstrb   (s_axi_wstrb),
  .s_axi_wvalid  (s_axi_wvalid),
  .s_axi_wready  (s_axi_wready),
  .s_axi_bresp   (s_axi_bresp),
  .s_axi_bvalid  (s_axi_bvalid),
  .s_axi_bready  (s_axi_bready),
  .s_axi_araddr  (s_axi_araddr),
  .s_axi_arvalid (s_axi_arvalid),
  .s_axi_arready (s_axi_arready),
  .s_axi_rdata   (s_axi_rdata),
  .s_axi_rresp   (s_axi_rresp),
  .s_axi_rvalid  (s_axi_rvalid),
  .s_axi_rready  (s_axi_rready),
  .cmd           (cmd),
  .num_pkts      (num_pkts)
);

// ==== logic/dma_regs_top.sv ====
////////////////////////////////////////////////////////////////////////////
// DMA control register block on AXI4-Lite, drives cmd and num_pkts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_regs_top (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  // Write address and data
  input  logic [axi_lite_pkg::AXI_ADDR_W-1:0] s_axi_awaddr,
  input  logic                                s_axi_awvalid,
  output logic                                s_axi_awready,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0] s_axi_wdata,
  input  logic [axi_lite_pkg::AXI_STRB_W-1:0] s_axi_wstrb,
  input  logic                                s_axi_wvalid,
  output logic                                s_axi_wready,
  // Write response
  output logic [1:0]                          s_axi_bresp,
  output logic                                s_axi_bvalid,
  input  logic                                s_axi_bready,
  // Read address
  input  logic [axi_lite_pkg::AXI_ADDR_W-1:0] s_axi_araddr,
  input  logic                                s_axi_arvalid,
  output logic                                s_axi_arready,
  // Read data and response
  output logic [axi_lite_pkg::AXI_DATA_W-1:0] s_axi_rdata,
  output logic [1:0]                          s_axi_rresp,
  output logic                                s_axi_rvalid,
  input  logic                                s_axi_rready,
  // To the DMA engine
  output dma_regs_pkg::reg_word_t             cmd,
  output dma_regs_pkg::reg_word_t             num_pkts
);

  import dma_regs_pkg::*;

  // Write bus shared by every slice
  reg_wr_t   reg_wr;
  // All register words, read back by the read channel
  reg_file_t regs;

  axi_write_channel #(
    .NUM_REGS (NUM_REGS)
  ) u_write (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_awready (s_axi_awready),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .reg_wr        (reg_wr)
  );

  // One slice per implemented register
  for (genvar i = 0; i < NUM_REGS; i++)
  begin : g_slice
    dma_reg_slice #(
      .REG_INDEX (i)
    ) u_slice (
      .S_AXI_ACLK    (S_AXI_ACLK),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .reg_wr        (reg_wr),
      .word          (regs[i])
    );
  end

  axi_read_channel #(
    .NUM_REGS (NUM_REGS)
  ) u_read (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_rready  (s_axi_rready),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .regs          (regs)
  );

  // Engine-facing copies of the command and packet count words
  assign cmd      = regs[REG_CMD];
  assign num_pkts = regs[REG_NUM_PKTS];

endmodule

// ==== logic/axi_read_channel.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite read path, latches the address and returns the register word
// with OKAY, held until the master takes it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_read_channel #(
  parameter int NUM_REGS = dma_regs_pkg::NUM_REGS
) (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic [axi_lite_pkg::AXI_ADDR_W-1:0] s_axi_araddr,
  input  logic                                s_axi_arvalid,
  input  logic                                s_axi_rready,
  output logic                                s_axi_arready,
  output logic [axi_lite_pkg::AXI_DATA_W-1:0] s_axi_rdata,
  output logic [1:0]                          s_axi_rresp,
  output logic                                s_axi_rvalid,
  input  dma_regs_pkg::reg_file_t             regs
);

  import axi_lite_pkg::*;
  import dma_regs_pkg::*;

  logic                  arready_q;
  logic                  ar_accept;
  logic [AXI_ADDR_W-1:0] araddr_q;
  logic [REG_IDX_W-1:0]  rd_idx;
  reg_word_t             rd_word;
  reg_word_t             rdata_q;
  // Read response state
  axi_rsp_t              r_q;

  // One read in flight, no new address while data is pending
  assign ar_accept = s_axi_arvalid && !arready_q && !r_q.valid;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready_q <= 1'b0;
    end
    else
    begin
      arready_q <= ar_accept;
    end
  end

  // Address latched as arready rises
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (ar_accept)
    begin
      araddr_q <= s_axi_araddr;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Register select, empty slots read as zero
  ////////////////////////////////////////////////////////////////////////

  assign rd_idx = araddr_q[AXI_ADDR_W-1:ADDR_LSB];

  always_comb
  begin
    rd_word = '0;
    for (int i = 0; i < NUM_REGS; i++)
    begin
      if (rd_idx == REG_IDX_W'(i))
      begin
        rd_word = regs[i];
      end
    end
  end

  // Data captured at the end of the arready cycle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (arready_q)
    begin
      rdata_q <= rd_word;
    end
  end

  // rvalid holds until rready
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      r_q <= '{valid: 1'b0, resp: RESP_OKAY};
    end
    else if (arready_q)
    begin
      r_q <= '{valid: 1'b1, resp: RESP_OKAY};
    end
    else if (r_q.valid && s_axi_rready)
    begin
      r_q.valid <= 1'b0;
    end
  end

  assign s_axi_arready = arready_q;
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = r_q.resp;
  assign s_axi_rvalid  = r_q.valid;

endmodule

// ==== logic/dma_reg_slice.sv ====
////////////////////////////////////////////////////////////////////////////
// One DMA control register with byte-lane write merge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_reg_slice #(
  parameter int REG_INDEX = 0
) (
  input  logic                    S_AXI_ACLK,
  input  logic                    S_AXI_ARESETN,
  input  dma_regs_pkg::reg_wr_t   reg_wr,
  output dma_regs_pkg::reg_word_t word
);

  import dma_regs_pkg::*;

  // This slice is the target of the current write
  logic hit;

  assign hit = reg_wr.en && (reg_wr.idx == REG_IDX_W'(REG_INDEX));

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      word <= '0;
    end
    else if (hit)
    begin
      // Only strobed byte lanes change, others keep their value
      for (int b = 0; b < REG_BYTES; b++)
      begin
        if (reg_wr.strb[b])
        begin
          word[b*8 +: 8] <= reg_wr.data[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== logic/axi_write_channel.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite write path, turns one write handshake into a register write
// and holds the OKAY response until the master takes it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_write_channel #(
  parameter int NUM_REGS = dma_regs_pkg::NUM_REGS
) (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic [axi_lite_pkg::AXI_ADDR_W-1:0] s_axi_awaddr,
  input  logic [axi_lite_pkg::AXI_DATA_W-1:0] s_axi_wdata,
  input  logic [axi_lite_pkg::AXI_STRB_W-1:0] s_axi_wstrb,
  input  logic                                s_axi_awvalid,
  input  logic                                s_axi_wvalid,
  input  logic                                s_axi_bready,
  output logic                                s_axi_awready,
  output logic                                s_axi_wready,
  output logic [1:0]                          s_axi_bresp,
  output logic                                s_axi_bvalid,
  output dma_regs_pkg::reg_wr_t               reg_wr
);

  import axi_lite_pkg::*;
  import dma_regs_pkg::*;

  // Captured address, data and strobes
  axi_aw_t              aw_q;
  // Write response state
  axi_rsp_t             b_q;
  // Shared ready for AW and W, high for one cycle per write
  logic                 ready_q;
  logic                 accept;
  logic [REG_IDX_W-1:0] wr_idx;

  // Take a write only with both channels valid and no response pending
  assign accept = s_axi_awvalid && s_axi_wvalid && !ready_q && !b_q.valid;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      ready_q <= 1'b0;
    end
    else
    begin
      ready_q <= accept;
    end
  end

  // Payload latch, loaded on the same edge the readies rise
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
    begin
      aw_q <= '{addr: s_axi_awaddr, data: s_axi_wdata, strb: s_axi_wstrb};
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Register write, issued during the ready cycle
  ////////////////////////////////////////////////////////////////////////

  assign wr_idx = aw_q.addr[AXI_ADDR_W-1:ADDR_LSB];

  always_comb
  begin
    // Slots beyond the map get a response but no write
    reg_wr.en   = ready_q && (int'(wr_idx) < NUM_REGS);
    reg_wr.idx  = wr_idx;
    reg_wr.data = aw_q.data;
    reg_wr.strb = aw_q.strb;
  end

  // Response rises as the write lands, held until bready
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      b_q <= '{valid: 1'b0, resp: RESP_OKAY};
    end
    else if (ready_q)
    begin
      b_q <= '{valid: 1'b1, resp: RESP_OKAY};
    end
    else if (b_q.valid && s_axi_bready)
    begin
      b_q.valid <= 1'b0;
    end
  end

  assign s_axi_awready = ready_q;
  assign s_axi_wready  = ready_q;
  assign s_axi_bvalid  = b_q.valid;
  assign s_axi_bresp   = b_q.resp;

endmodule

// ==== logic/dma_regs_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// DMA control register map, word type and register write bus
// Imported by the write channel, the register slices and the read path
////////////////////////////////////////////////////////////////////////////

package dma_regs_pkg;

  // Register word width and its byte lanes
  parameter int REG_W     = 32;
  parameter int REG_BYTES = REG_W / 8;

  // Number of implemented registers, slot 7 is left empty
  parameter int NUM_REGS  = 7;
  // Word index width, wide enough for all eight address slots
  parameter int REG_IDX_W = 3;

  ////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////

  // Command word driven out to the DMA engine
  parameter int REG_CMD      = 0;
  // Packet count driven out to the DMA engine
  parameter int REG_NUM_PKTS = 2;

  // One control register word
  typedef logic [REG_W-1:0] reg_word_t;

  // Single-cycle register write, enable plus target and byte lanes
  typedef struct packed {
    logic                 en;
    logic [REG_IDX_W-1:0] idx;
    reg_word_t            data;
    logic [REG_BYTES-1:0] strb;
  } reg_wr_t;

  // All register words side by side, index 0 at the low end
  typedef reg_word_t [NUM_REGS-1:0] reg_file_t;

endpackage

// ==== logic/axi_lite_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite bus widths, response codes and channel structs
// Imported by the bus-facing write and read channel modules
////////////////////////////////////////////////////////////////////////////

package axi_lite_pkg;

  // Data bus width in bits
  parameter int AXI_DATA_W = 32;
  // Byte address width, covers eight 32-bit slots
  parameter int AXI_ADDR_W = 5;
  // One strobe bit per data byte
  parameter int AXI_STRB_W = AXI_DATA_W / 8;
  // Byte offset bits dropped to form a word index
  parameter int ADDR_LSB = 2;

  // Response codes
  parameter logic [1:0] RESP_OKAY = 2'b00;

  // Write address, data and strobes, captured in the same cycle
  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
  } axi_aw_t;

  // Response channel state: valid flag with its 2-bit code
  typedef struct packed {
    logic       valid;
    logic [1:0] resp;
  } axi_rsp_t;

endpackage
